/* col_handshake.sv */
`default_nettype none

module col_handshake
    import window_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic col_req_i,
    input  col_t col_i,
    output logic col_ack_o,
    output logic shift_en_o,
    output col_t col_o
);

    hs_state_e state_q;
    hs_state_e state_d;
    logic      capture;

    // ########################################
    // four-phase receiver FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            HS_IDLE: begin
                if (col_req_i) begin
                    state_d = HS_ACK;
                end
            end
            HS_ACK: begin
                // ack stays up for as long as the producer holds req
                if (!col_req_i) begin
                    state_d = HS_RELEASE;
                end
            end
            HS_RELEASE: begin
                // ack is already low here, producer may start the next transfer
                state_d = HS_IDLE;
            end
            default: begin
                state_d = HS_IDLE;
            end
        endcase
    end

    // only a new request in idle loads a column
    assign capture = (state_q == HS_IDLE) && col_req_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= HS_IDLE;
            shift_en_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            shift_en_o <= capture;
        end
    end

    // ########################################
    // column capture

    always_ff @(posedge clk) begin
        if (capture) begin
            col_o <= col_i;
        end
    end

    // ack rises with the capture edge and falls on the edge req is seen low
    assign col_ack_o = (state_q == HS_ACK);

endmodule

`default_nettype wire

/* flist.f */
window_pkg.sv
col_handshake.sv
window_position.sv
window_shift.sv
window_buffer_17x17.sv
tb_clk_gen.sv
window_buffer_sva.sv
tb_window_buffer.sv

/* run.sh */
#!/bin/sh
# compile and run the window buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_window_buffer -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

grep -qx "ALL CHECKS PASSED" "$LOG" && echo "run.sh: simulation passed" && exit 0 \
    || { echo "run.sh: simulation failed, see $LOG"; exit 1; }

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // period of 4 time units
    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o;

    // reset held for the first 16 rising edges
    initial begin
        rst_o <= 1'b1;
        repeat (16) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_window_buffer.sv */
`default_nettype none

module tb_window_buffer
    import window_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        col_req;
    col_t        col_data;
    logic        col_ack;
    window_t     win_out;
    win_status_t status_out;

    // reference model of the window and its position
    window_t     model_win;
    int          model_col;
    int          model_row;

    logic [31:0] lfsr_q;
    int          check_cnt;
    int          error_cnt;
    int          cycle_cnt = 0;

    tb_clk_gen tb_clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    window_buffer_17x17 window_buffer_17x17_i (
        .clk       (clk),
        .rst       (rst),
        .col_req_i (col_req),
        .col_i     (col_data),
        .col_ack_o (col_ack),
        .window_o  (win_out),
        .status_o  (status_out)
    );

    // ########################################
    // watchdog

    // reset, then 4 cycles per column over a frame of window rows, three times over
    function automatic int cycle_limit();
        return 16 + 4 * IMG_COLS * (IMG_ROWS - WIN_SIZE + 1) * 3 + 200;
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit()) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ########################################
    // stimulus helpers

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic random_column(output col_t c);
        for (int r = 0; r < WIN_SIZE; r++) begin
            for (int b = 0; b < PIX_W; b++) begin
                c[r][b] = lfsr_q[0];
                lfsr_q  = lfsr_next(lfsr_q);
            end
        end
    endtask

    // one four-phase transfer, returns once ack is low again
    task automatic send_column(input col_t c, input int hold);
        @(posedge clk);
        col_req  <= 1'b1;
        col_data <= c;
        @(negedge clk);
        while (!col_ack) @(negedge clk);
        repeat (hold) begin
            @(negedge clk);
            check_bit(col_ack, 1'b1, "ack while req is held");
        end
        @(posedge clk);
        col_req <= 1'b0;
        @(negedge clk);
        while (col_ack) @(negedge clk);
    endtask

    // ########################################
    // model and checks

    task automatic model_capture(input col_t c, output win_status_t expected);
        for (int i = 0; i < WIN_SIZE - 1; i++) begin
            model_win[i] = model_win[i + 1];
        end
        model_win[WIN_SIZE-1] = c;
        expected.valid     = (model_col + 1 >= WIN_SIZE);
        expected.row_end   = (model_col == IMG_COLS - 1);
        expected.frame_end = expected.row_end && (model_row == IMG_ROWS - WIN_SIZE);
        if (expected.row_end) begin
            model_col = 0;
            model_row = expected.frame_end ? 0 : model_row + 1;
        end else begin
            model_col++;
        end
    endtask

    task automatic check_bit(input logic got, input logic expected, input string what);
        check_cnt++;
        assert (got === expected) else begin
            error_cnt++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic compare_window(input string what);
        int bad = 0;
        int first_c = 0;
        int first_r = 0;
        for (int c = 0; c < WIN_SIZE; c++) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                if (win_out[c][r] !== model_win[c][r]) begin
                    if (bad == 0) begin
                        first_c = c;
                        first_r = r;
                    end
                    bad++;
                end
            end
        end
        check_cnt++;
        assert (bad == 0) else begin
            error_cnt++;
            $display("[ERROR] %0t: %s has %0d wrong pixels, first at [%0d][%0d]: %h expected %h",
                     $time, what, bad, first_c, first_r,
                     win_out[first_c][first_r], model_win[first_c][first_r]);
        end
    endtask

    // send one column and compare window and status with the model
    task automatic transfer_column(input col_t c, input int hold);
        win_status_t expected;
        send_column(c, hold);
        model_capture(c, expected);
        compare_window("window");
        check_bit(status_out.valid, expected.valid, "valid");
        check_bit(status_out.row_end, expected.row_end, "row_end");
        check_bit(status_out.frame_end, expected.frame_end, "frame_end");
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_cnt == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_cnt - errors_before);
        end
    endtask

    // ########################################
    // directed tests

    task automatic reset_values();
        int errors_before;
        errors_before = error_cnt;
        compare_window("window after reset");
        check_bit(status_out.valid, 1'b0, "valid after reset");
        check_bit(status_out.row_end, 1'b0, "row_end after reset");
        check_bit(status_out.frame_end, 1'b0, "frame_end after reset");
        check_bit(col_ack, 1'b0, "ack after reset");
        report_test("reset values", errors_before);
    endtask

    task automatic handshake_hold();
        int   errors_before;
        col_t c;
        errors_before = error_cnt;
        random_column(c);
        // a doubled capture would shift the window twice and miss the model
        transfer_column(c, 6);
        report_test("handshake with held req", errors_before);
    endtask

    task automatic window_contents();
        int   errors_before;
        col_t c;
        errors_before = error_cnt;
        for (int i = 0; i < 30; i++) begin
            random_column(c);
            transfer_column(c, 0);
        end
        report_test("window contents", errors_before);
    endtask

    task automatic valid_flag();
        int   errors_before;
        col_t c;
        errors_before = error_cnt;
        // finish the current row first
        while (model_col != 0) begin
            random_column(c);
            transfer_column(c, 0);
        end
        for (int i = 0; i < IMG_COLS; i++) begin
            random_column(c);
            transfer_column(c, 0);
            check_bit(status_out.valid, logic'(i >= WIN_SIZE - 1),
                      $sformatf("valid at column %0d", i));
        end
        report_test("valid flag", errors_before);
    endtask

    task automatic row_frame_flags();
        int   errors_before;
        int   start_row;
        int   row;
        int   col;
        int   frames;
        col_t c;
        errors_before = error_cnt;
        start_row = model_row;
        frames = 0;
        // five rows always pass the last window row and the restart after it
        for (int n = 0; n < (IMG_ROWS - WIN_SIZE + 2) * IMG_COLS; n++) begin
            row = (start_row + n / IMG_COLS) % (IMG_ROWS - WIN_SIZE + 1);
            col = n % IMG_COLS;
            random_column(c);
            transfer_column(c, 0);
            check_bit(status_out.row_end, logic'(col == IMG_COLS - 1),
                      $sformatf("row_end at row %0d column %0d", row, col));
            check_bit(status_out.frame_end,
                      logic'(col == IMG_COLS - 1 && row == IMG_ROWS - WIN_SIZE),
                      $sformatf("frame_end at row %0d column %0d", row, col));
            check_bit(status_out.valid, logic'(col >= WIN_SIZE - 1),
                      $sformatf("valid at row %0d column %0d", row, col));
            if (status_out.frame_end) begin
                frames++;
            end
        end
        check_bit(logic'(frames >= 1), 1'b1, "frame_end seen at least once");
        report_test("row and frame flags", errors_before);
    endtask

    // ########################################
    // main sequence

    initial begin
        col_req   <= 1'b0;
        col_data  <= '0;
        model_win = '0;
        model_col = 0;
        model_row = 0;
        lfsr_q    = 32'hb3e6b48c;
        check_cnt = 0;
        error_cnt = 0;

        @(negedge clk);
        while (rst) @(negedge clk);

        reset_values();
        handshake_hold();
        window_contents();
        valid_flag();
        row_frame_flags();

        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* window_buffer_17x17.sv */
`default_nettype none

module window_buffer_17x17
    import window_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        col_req_i,
    input  col_t        col_i,
    output logic        col_ack_o,
    output window_t     window_o,
    output win_status_t status_o
);

    logic shift_en;
    col_t cap_col;

    // ########################################
    // column input

    // one strobe per completed request, with the column it captured
    col_handshake col_handshake_i (
        .clk        (clk),
        .rst        (rst),
        .col_req_i  (col_req_i),
        .col_i      (col_i),
        .col_ack_o  (col_ack_o),
        .shift_en_o (shift_en),
        .col_o      (cap_col)
    );

    // ########################################
    // window and position

    window_shift window_shift_i (
        .clk        (clk),
        .rst        (rst),
        .shift_en_i (shift_en),
        .col_i      (cap_col),
        .window_o   (window_o)
    );

    // both update on the same edge, so window and status stay aligned
    window_position window_position_i (
        .clk        (clk),
        .rst        (rst),
        .shift_en_i (shift_en),
        .status_o   (status_o)
    );

endmodule

`default_nettype wire

/* window_buffer_sva.sv */
`default_nettype none

module window_buffer_sva
    import window_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        col_req_i,
    input logic        col_ack_i,
    input win_status_t status_i
);

    // ########################################
    // handshake

    // ack only answers a request that is present
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(col_ack_i) |-> $past(col_req_i)
    ) else $error("ack rose while req was low");

    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (rst) $fell(col_ack_i) |-> !$past(col_req_i)
    ) else $error("ack fell while req was still high");

    // a producer that keeps req up keeps ack up
    ack_held_with_req: assert property (
        @(posedge clk) disable iff (rst) (col_ack_i && col_req_i) |=> col_ack_i
    ) else $error("ack dropped while req was held high");

    // ########################################
    // reset

    status_clear_in_reset: assert property (
        @(posedge clk) rst |=> (status_i == '0)
    ) else $error("status not cleared by reset");

    ack_low_in_reset: assert property (
        @(posedge clk) rst |=> !col_ack_i
    ) else $error("ack high during reset");

endmodule

bind window_buffer_17x17 window_buffer_sva window_buffer_sva_i (
    .clk       (clk),
    .rst       (rst),
    .col_req_i (col_req_i),
    .col_ack_i (col_ack_o),
    .status_i  (status_o)
);

`default_nettype wire

/* window_pkg.sv */
`default_nettype none

package window_pkg;

    // ########################################
    // image geometry

    localparam int PIX_W    = 8;
    localparam int WIN_SIZE = 17;
    localparam int IMG_COLS = 24;
    localparam int IMG_ROWS = 20;

    // wide enough for a column index within a row
    localparam int CNT_W = 5;

    // last column of a row
    localparam int LAST_COL = IMG_COLS - 1;
    // last row index at which a full window still fits in the image
    localparam int LAST_WIN_ROW = IMG_ROWS - WIN_SIZE;

    // ########################################
    // pixel data

    typedef logic [PIX_W-1:0] pixel_t;

    // one column from the line buffer, index 0 is the top row
    typedef pixel_t [WIN_SIZE-1:0] col_t;

    // index 0 is the oldest column, index WIN_SIZE-1 the newest
    typedef col_t [WIN_SIZE-1:0] window_t;

    // ########################################
    // control and status

    typedef struct packed {
        logic valid;
        logic row_end;
        logic frame_end;
    } win_status_t;

    typedef enum logic [1:0] {
        HS_IDLE    = 2'd0,
        HS_ACK     = 2'd1,
        HS_RELEASE = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

/* window_position.sv */
`default_nettype none

module window_position
    import window_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        shift_en_i,
    output win_status_t status_o
);

    logic [CNT_W-1:0] col_cnt_q;
    logic [CNT_W-1:0] row_cnt_q;
    logic             last_col;
    logic             last_row;
    logic             win_full;

    // ########################################
    // position of the column being captured

    // col_cnt_q is the index of the incoming column within its row
    assign last_col = (col_cnt_q == CNT_W'(LAST_COL));
    assign last_row = (row_cnt_q == CNT_W'(LAST_WIN_ROW));

    // the incoming column is number col_cnt_q + 1 of the row
    assign win_full = (col_cnt_q >= CNT_W'(WIN_SIZE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt_q <= '0;
            row_cnt_q <= '0;
        end else if (shift_en_i) begin
            if (last_col) begin
                col_cnt_q <= '0;
                // wrap after the last row that holds a full window
                if (last_row) begin
                    row_cnt_q <= '0;
                end else begin
                    row_cnt_q <= row_cnt_q + CNT_W'(1);
                end
            end else begin
                col_cnt_q <= col_cnt_q + CNT_W'(1);
            end
        end
    end

    // ########################################
    // status flags, held until the next capture

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o <= '0;
        end else if (shift_en_i) begin
            status_o.valid     <= win_full;
            status_o.row_end   <= last_col;
            status_o.frame_end <= last_col && last_row;
        end
    end

endmodule

`default_nettype wire

/* window_shift.sv */
`default_nettype none

module window_shift
    import window_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    shift_en_i,
    input  col_t    col_i,
    output window_t window_o
);

    // ########################################
    // column shift array

    // columns move toward index 0, the oldest one drops out
    always_ff @(posedge clk) begin
        if (rst) begin
            window_o <= '0;
        end else if (shift_en_i) begin
            for (int c = 0; c < WIN_SIZE - 1; c++) begin
                window_o[c] <= window_o[c + 1];
            end
            // newest column enters on the right
            window_o[WIN_SIZE-1] <= col_i;
        end
    end

endmodule

`default_nettype wire
